// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath geometry
`define RV_XLEN  32
`define RV_NREGS 32

// base opcodes of the supported subset
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_BRANCH 7'b1100011

`endif

// ==== rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]          rv_word;    // data, pc, immediates
    typedef logic [$clog2(`RV_NREGS)-1:0] rv_reg_idx;
    typedef logic [2:0]                   rv_funct3;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic {
        src_a_reg,
        src_a_pc     // auipc
    } src_a_sel_e;

    typedef enum logic {
        src_b_reg,
        src_b_imm
    } src_b_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,      // lui
        wb_pc_plus4  // link value of jal
    } wb_sel_e;

endpackage

// ==== rv_ifs.sv ====
`timescale 1ns/100ps

// register indices and immediate from the decoder
interface decode_fields_if;
    import rv_pkg::*;

    rv_reg_idx rs1;
    rv_reg_idx rs2;
    rv_reg_idx rd;
    rv_word    imm;

    modport src (output rs1, output rs2, output rd, output imm);
    modport rf  (input rs1, input rs2);
    modport exe (input rs1, input rs2, input rd, input imm);
endinterface

// control word from the control unit to execute
interface ctrl_word_if;
    import rv_pkg::*;

    alu_op_e    alu_op;
    src_a_sel_e src_a_sel;
    src_b_sel_e src_b_sel;
    wb_sel_e    wb_sel;
    logic       reg_write;
    logic       is_branch;
    logic       is_jump;
    rv_funct3   br_funct3;

    modport src (
        output alu_op, output src_a_sel, output src_b_sel, output wb_sel,
        output reg_write, output is_branch, output is_jump, output br_funct3
    );
    modport exe (
        input alu_op, input src_a_sel, input src_b_sel, input wb_sel,
        input reg_write, input is_branch, input is_jump, input br_funct3
    );
endinterface

// ==== instr_fields.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module instr_fields (
    input  rv_pkg::rv_word  i_instr,
    decode_fields_if.src    fields
);
    import rv_pkg::*;

    logic [6:0] opcode;
    rv_word     imm_i;
    rv_word     imm_u;
    rv_word     imm_b;
    rv_word     imm_j;

    assign opcode = i_instr[6:0];

    assign fields.rs1 = i_instr[19:15];
    assign fields.rs2 = i_instr[24:20];
    assign fields.rd  = i_instr[11:7];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_b = {
        {19{i_instr[31]}},
        i_instr[31],
        i_instr[7],
        i_instr[30:25],
        i_instr[11:8],
        1'b0                // branch offsets are halfword aligned
    };
    assign imm_j = {
        {11{i_instr[31]}},
        i_instr[31],
        i_instr[19:12],
        i_instr[20],
        i_instr[30:21],
        1'b0
    };

    always_comb begin
        case (opcode)
            `RV_OP_LUI,
            `RV_OP_AUIPC:  fields.imm = imm_u;
            `RV_OP_JAL:    fields.imm = imm_j;
            `RV_OP_BRANCH: fields.imm = imm_b;
            default:       fields.imm = imm_i;  // op-imm, don't care for r-type
        endcase
    end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module control_unit (
    input  rv_pkg::rv_word  i_instr,
    input  logic            i_valid,
    ctrl_word_if.src        ctrl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    rv_funct3   funct3;
    logic       funct7_b5;

    // shared by op and op-imm, alt selects sub or sra
    function automatic alu_op_e alu_from_funct3(input rv_funct3 f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    assign ctrl.br_funct3 = funct3;  // comparator condition code

    always_comb begin
        ctrl.alu_op    = alu_add;
        ctrl.src_a_sel = src_a_reg;
        ctrl.src_b_sel = src_b_reg;
        ctrl.wb_sel    = wb_alu;
        ctrl.reg_write = 1'b0;       // bubble unless recognised
        ctrl.is_branch = 1'b0;
        ctrl.is_jump   = 1'b0;

        case (opcode)
            `RV_OP_OP: begin
                ctrl.alu_op    = alu_from_funct3(funct3, funct7_b5);
                ctrl.reg_write = i_valid;
            end
            `RV_OP_OP_IMM: begin
                // addi has no subtract form, bit 30 is immediate there
                ctrl.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7_b5);
                ctrl.src_b_sel = src_b_imm;
                ctrl.reg_write = i_valid;
            end
            `RV_OP_LUI: begin
                ctrl.wb_sel    = wb_imm;
                ctrl.reg_write = i_valid;
            end
            `RV_OP_AUIPC: begin
                ctrl.src_a_sel = src_a_pc;
                ctrl.src_b_sel = src_b_imm;
                ctrl.reg_write = i_valid;
            end
            `RV_OP_JAL: begin
                ctrl.wb_sel    = wb_pc_plus4;
                ctrl.reg_write = i_valid;
                ctrl.is_jump   = i_valid;
            end
            `RV_OP_BRANCH: begin
                ctrl.is_branch = i_valid;
            end
            default: ;
        endcase
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module regfile (
    input  logic              i_clk,
    input  logic              i_rst_n,
    decode_fields_if.rf       fields,
    input  logic              i_we,
    input  rv_pkg::rv_reg_idx i_waddr,
    input  rv_pkg::rv_word    i_wdata,
    output rv_pkg::rv_word    o_rdata1,
    output rv_pkg::rv_word    o_rdata2
);
    import rv_pkg::*;

    rv_word regs [`RV_NREGS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin  // x0 writes dropped
            regs[i_waddr] <= i_wdata;
        end
    end

    // async read, x0 forced to zero
    assign o_rdata1 = (fields.rs1 == '0) ? '0 : regs[fields.rs1];
    assign o_rdata2 = (fields.rs2 == '0) ? '0 : regs[fields.rs2];

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module execute_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    decode_fields_if.exe      fields,
    ctrl_word_if.exe          ctrl,
    input  rv_pkg::rv_word    i_pc,
    input  rv_pkg::rv_word    i_rdata1,
    input  rv_pkg::rv_word    i_rdata2,
    output logic              o_we,
    output rv_pkg::rv_reg_idx o_waddr,
    output rv_pkg::rv_word    o_wdata,
    output logic              o_br_valid,
    output logic              o_br_taken,
    output rv_pkg::rv_word    o_br_target
);
    import rv_pkg::*;

    // id/ex stage
    alu_op_e    ex_alu_op;
    src_a_sel_e ex_src_a_sel;
    src_b_sel_e ex_src_b_sel;
    wb_sel_e    ex_wb_sel;
    logic       ex_reg_write;
    logic       ex_is_branch;
    logic       ex_is_jump;
    rv_funct3   ex_br_funct3;
    rv_word     ex_pc;
    rv_word     ex_imm;
    rv_reg_idx  ex_rd;
    rv_word     ex_op1;
    rv_word     ex_op2;

    // writeback stage
    logic       wb_we;
    rv_reg_idx  wb_rd;
    rv_word     wb_data;
    logic       wb_br_valid;
    logic       wb_br_taken;
    rv_word     wb_br_target;

    logic       ex_we;
    rv_word     fwd1;
    rv_word     fwd2;
    rv_word     alu_a;
    rv_word     alu_b;
    rv_word     alu_out;
    logic       br_cond;
    rv_word     ex_result;

    assign ex_we = ex_reg_write && (ex_rd != '0);

    // execute result first, then writeback register, then regfile
    assign fwd1 = (ex_we && fields.rs1 == ex_rd) ? ex_result :
                  (wb_we && fields.rs1 == wb_rd) ? wb_data : i_rdata1;
    assign fwd2 = (ex_we && fields.rs2 == ex_rd) ? ex_result :
                  (wb_we && fields.rs2 == wb_rd) ? wb_data : i_rdata2;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ex_alu_op    <= alu_add;
            ex_src_a_sel <= src_a_reg;
            ex_src_b_sel <= src_b_reg;
            ex_wb_sel    <= wb_alu;
            ex_reg_write <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_br_funct3 <= '0;
            wb_we        <= 1'b0;
            wb_br_valid  <= 1'b0;
            wb_br_taken  <= 1'b0;
        end else begin
            ex_alu_op    <= ctrl.alu_op;
            ex_src_a_sel <= ctrl.src_a_sel;
            ex_src_b_sel <= ctrl.src_b_sel;
            ex_wb_sel    <= ctrl.wb_sel;
            ex_reg_write <= ctrl.reg_write;
            ex_is_branch <= ctrl.is_branch;
            ex_is_jump   <= ctrl.is_jump;
            ex_br_funct3 <= ctrl.br_funct3;
            wb_we        <= ex_we;
            wb_br_valid  <= ex_is_branch || ex_is_jump;  // one pulse per branch/jal
            wb_br_taken  <= (ex_is_branch && br_cond) || ex_is_jump;
        end
    end

    always_ff @(posedge i_clk) begin
        ex_pc        <= i_pc;
        ex_imm       <= fields.imm;
        ex_rd        <= fields.rd;
        ex_op1       <= fwd1;
        ex_op2       <= fwd2;
        wb_rd        <= ex_rd;
        wb_data      <= ex_result;
        wb_br_target <= ex_pc + ex_imm;
    end

    assign alu_a = (ex_src_a_sel == src_a_pc)  ? ex_pc  : ex_op1;
    assign alu_b = (ex_src_b_sel == src_b_imm) ? ex_imm : ex_op2;

    always_comb begin
        case (ex_alu_op)
            alu_sub:  alu_out = alu_a - alu_b;
            alu_sll:  alu_out = alu_a << alu_b[4:0];
            alu_slt:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_out = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            alu_xor:  alu_out = alu_a ^ alu_b;
            alu_srl:  alu_out = alu_a >> alu_b[4:0];
            alu_sra:  alu_out = $signed(alu_a) >>> alu_b[4:0];
            alu_or:   alu_out = alu_a | alu_b;
            alu_and:  alu_out = alu_a & alu_b;
            default:  alu_out = alu_a + alu_b;
        endcase
    end

    // branch compare always on the two register operands
    always_comb begin
        case (ex_br_funct3)
            3'b000:  br_cond = (ex_op1 == ex_op2);
            3'b001:  br_cond = (ex_op1 != ex_op2);
            3'b100:  br_cond = ($signed(ex_op1) < $signed(ex_op2));
            3'b101:  br_cond = ($signed(ex_op1) >= $signed(ex_op2));
            3'b110:  br_cond = (ex_op1 < ex_op2);
            3'b111:  br_cond = (ex_op1 >= ex_op2);
            default: br_cond = 1'b0;  // reserved encodings never taken
        endcase
    end

    always_comb begin
        case (ex_wb_sel)
            wb_imm:      ex_result = ex_imm;
            wb_pc_plus4: ex_result = ex_pc + 32'd4;
            default:     ex_result = alu_out;
        endcase
    end

    assign o_we        = wb_we;
    assign o_waddr     = wb_rd;
    assign o_wdata     = wb_data;
    assign o_br_valid  = wb_br_valid;
    assign o_br_taken  = wb_br_taken;
    assign o_br_target = wb_br_target;

endmodule

// ==== datapath_top.sv ====
`timescale 1ns/100ps

module datapath_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  rv_pkg::rv_word    i_instr,
    input  rv_pkg::rv_word    i_pc,
    output logic              o_wb_valid,
    output rv_pkg::rv_reg_idx o_wb_rd,
    output rv_pkg::rv_word    o_wb_data,
    output logic              o_br_valid,
    output logic              o_br_taken,
    output rv_pkg::rv_word    o_br_target
);
    import rv_pkg::*;

    rv_word rdata1;
    rv_word rdata2;

    decode_fields_if fields_if ();
    ctrl_word_if     ctrl_if ();

    instr_fields i_instr_fields (
        .i_instr (i_instr),
        .fields  (fields_if)
    );

    control_unit i_control_unit (
        .i_instr (i_instr),
        .i_valid (i_valid),
        .ctrl    (ctrl_if)
    );

    // write port fed straight from the writeback register
    regfile i_regfile (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .fields   (fields_if),
        .i_we     (o_wb_valid),
        .i_waddr  (o_wb_rd),
        .i_wdata  (o_wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    execute_stage i_execute_stage (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .fields      (fields_if),
        .ctrl        (ctrl_if),
        .i_pc        (i_pc),
        .i_rdata1    (rdata1),
        .i_rdata2    (rdata2),
        .o_we        (o_wb_valid),
        .o_waddr     (o_wb_rd),
        .o_wdata     (o_wb_data),
        .o_br_valid  (o_br_valid),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target)
    );

endmodule

// ==== wb_checker.sv ====
`timescale 1ns/100ps

module wb_checker (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  logic              i_wb_valid,
    input  rv_pkg::rv_reg_idx i_wb_rd,
    input  rv_pkg::rv_word    i_wb_data,
    input  logic              i_br_valid,
    input  logic              i_br_taken,
    input  rv_pkg::rv_word    i_br_target,
    output int                o_checks,
    output int                o_mismatches,
    output int                o_strobe_errors
);
    import rv_pkg::*;

    typedef struct packed {
        logic      wb_valid;
        rv_reg_idx wb_rd;
        rv_word    wb_data;
        logic      br_valid;
        logic      br_taken;
        rv_word    br_target;
    } result_t;

    result_t expected [$];        // filled by the testbench as it drives
    logic    accepted_d1;
    logic    accepted_d2;         // results of this one are on the outputs now
    int      checks = 0;
    int      mismatches = 0;
    int      strobe_errors = 0;

    assign o_checks        = checks;
    assign o_mismatches    = mismatches;
    assign o_strobe_errors = strobe_errors;

    task automatic expect_result(
        input logic      wb_valid,
        input rv_reg_idx wb_rd,
        input rv_word    wb_data,
        input logic      br_valid,
        input logic      br_taken,
        input rv_word    br_target
    );
        expected.push_back({wb_valid, wb_rd, wb_data, br_valid, br_taken, br_target});
    endtask

    function automatic int pending();
        return expected.size();
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            strobe_errors++;
            if (want)
                $display("%s stayed low for an accepted instruction at %0t", name, $time);
            else
                $display("%s pulsed with no result expected at %0t", name, $time);
        end
    endtask

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            accepted_d1 <= 1'b0;
            accepted_d2 <= 1'b0;
        end else begin
            accepted_d1 <= i_valid;
            accepted_d2 <= accepted_d1;
        end
    end

    // outputs sampled on the falling edge
    always @(negedge i_clk) begin : compare_outputs
        result_t want;
        if (i_rst_n) begin
            if (accepted_d2 && expected.size() != 0) begin
                want = expected.pop_front();
                check_strobe("o_wb_valid", i_wb_valid, want.wb_valid);
                if (want.wb_valid && i_wb_valid) begin
                    compare_value("o_wb_rd", {27'b0, i_wb_rd}, {27'b0, want.wb_rd});
                    compare_value("o_wb_data", i_wb_data, want.wb_data);
                end
                check_strobe("o_br_valid", i_br_valid, want.br_valid);
                if (want.br_valid && i_br_valid) begin
                    compare_value("o_br_taken", {31'b0, i_br_taken}, {31'b0, want.br_taken});
                    compare_value("o_br_target", i_br_target, want.br_target);
                end
            end else begin
                if (accepted_d2) begin
                    strobe_errors++;
                    $display("accepted instruction has no expected record at %0t", $time);
                end
                check_strobe("o_wb_valid", i_wb_valid, 1'b0);
                check_strobe("o_br_valid", i_br_valid, 1'b0);
            end
        end
    end

endmodule

// ==== tb_datapath.sv ====
`timescale 1ns/100ps

module tb_datapath;
    import rv_pkg::*;

    typedef struct packed {
        rv_word    instr;
        rv_word    pc;
        logic      wb_valid;
        rv_reg_idx wb_rd;
        rv_word    wb_data;
        logic      br_valid;
        logic      br_taken;
        rv_word    br_target;
    } stim_t;

    logic      clk;
    logic      rst_n;
    logic      valid;
    rv_word    instr;
    rv_word    pc;
    logic      wb_valid;
    rv_reg_idx wb_rd;
    rv_word    wb_data;
    logic      br_valid;
    logic      br_taken;
    rv_word    br_target;
    int        checks;
    int        mismatches;
    int        strobe_errors;
    stim_t     stim [$];
    int        cycles = 0;
    int        limit = 100000;   // replaced once the stimulus length is known
    logic [19:0] lfsr = 20'd99824;

    datapath_top i_datapath_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_valid     (valid),
        .i_instr     (instr),
        .i_pc        (pc),
        .o_wb_valid  (wb_valid),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data),
        .o_br_valid  (br_valid),
        .o_br_taken  (br_taken),
        .o_br_target (br_target)
    );

    wb_checker i_wb_checker (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_valid         (valid),
        .i_wb_valid      (wb_valid),
        .i_wb_rd         (wb_rd),
        .i_wb_data       (wb_data),
        .i_br_valid      (br_valid),
        .i_br_taken      (br_taken),
        .i_br_target     (br_target),
        .o_checks        (checks),
        .o_mismatches    (mismatches),
        .o_strobe_errors (strobe_errors)
    );

    // x^20 + x^17 + 1 with the new bit entering at bit 0
    function automatic logic [19:0] lfsr_step(input logic [19:0] state);
        return {state[18:0], state[19] ^ state[16]};
    endfunction

    task automatic draw_bubbles(output int count);
        lfsr = lfsr_step(lfsr);
        count = {31'b0, lfsr[0]};
        lfsr = lfsr_step(lfsr);
        count = count * 2 + {31'b0, lfsr[0]};
    endtask

    task automatic print_summary();
        $display("checks %0d, mismatches %0d, strobe errors %0d",
                 checks, mismatches, strobe_errors);
    endtask

    task automatic read_stimulus();
        int          fd;
        string       line;
        logic [31:0] w_instr, w_pc, w_wbv, w_rd, w_data, w_brv, w_taken, w_target;
        stim_t       rec;
        fd = $fopen("datapath_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open datapath_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip blanks and notes
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h", w_instr, w_pc, w_wbv,
                                w_rd, w_data, w_brv, w_taken, w_target) == 8) begin
                        rec = {w_instr, w_pc, w_wbv[0], w_rd[4:0], w_data,
                               w_brv[0], w_taken[0], w_target};
                        stim.push_back(rec);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("run stopped after %0d cycles, results still outstanding", cycles);
            print_summary();
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int n_bubbles;
        rst_n = 1'b0;
        valid = 1'b0;
        instr = '0;
        pc    = '0;
        read_stimulus();
        limit = 16 + 4 * stim.size() + 20;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (stim[i]) begin
            draw_bubbles(n_bubbles);
            repeat (n_bubbles) begin
                @(posedge clk);
                #2;
                valid = 1'b0;   // old instr left on the bus
            end
            @(posedge clk);
            #2;
            valid = 1'b1;
            instr = stim[i].instr;
            pc    = stim[i].pc;
            i_wb_checker.expect_result(stim[i].wb_valid, stim[i].wb_rd, stim[i].wb_data,
                                       stim[i].br_valid, stim[i].br_taken, stim[i].br_target);
        end
        @(posedge clk);
        #2;
        valid = 1'b0;
        while (i_wb_checker.pending() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // strobes must stay low in the idle tail
        print_summary();
        if (mismatches == 0 && strobe_errors == 0 && checks > 0 && stim.size() != 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== datapath_stimulus.txt ====
# columns in hex: instr pc wb_valid wb_rd wb_data br_valid br_taken br_target
# anything after the eighth column is ignored
FFB00093 00000100 1 01 FFFFFFFB 0 0 00000000  addi  x1, x0, -5
00C00113 00000104 1 02 0000000C 0 0 00000000  addi  x2, x0, 12
002081B3 00000108 1 03 00000007 0 0 00000000  add   x3, x1, x2
40110233 0000010C 1 04 00000011 0 0 00000000  sub   x4, x2, x1
002092B3 00000110 1 05 FFFFB000 0 0 00000000  sll   x5, x1, x2
0020A333 00000114 1 06 00000001 0 0 00000000  slt   x6, x1, x2
0020B3B3 00000118 1 07 00000000 0 0 00000000  sltu  x7, x1, x2
0020C433 0000011C 1 08 FFFFFFF7 0 0 00000000  xor   x8, x1, x2
0020D4B3 00000120 1 09 000FFFFF 0 0 00000000  srl   x9, x1, x2
4020D533 00000124 1 0A FFFFFFFF 0 0 00000000  sra   x10, x1, x2
0020E5B3 00000128 1 0B FFFFFFFF 0 0 00000000  or    x11, x1, x2
0020F633 0000012C 1 0C 00000008 0 0 00000000  and   x12, x1, x2
FFC0A693 00000130 1 0D 00000001 0 0 00000000  slti  x13, x1, -4
FFF13713 00000134 1 0E 00000001 0 0 00000000  sltiu x14, x2, -1
0F01C793 00000138 1 0F 000000F7 0 0 00000000  xori  x15, x3, 0xf0
4042D813 0000013C 1 10 FFFFFB00 0 0 00000000  srai  x16, x5, 4
00311893 00000140 1 11 00000060 0 0 00000000  slli  x17, x2, 3
01C0D913 00000144 1 12 0000000F 0 0 00000000  srli  x18, x1, 28
70166993 00000148 1 13 00000709 0 0 00000000  ori   x19, x12, 0x701
7F00FA13 0000014C 1 14 000007F0 0 0 00000000  andi  x20, x1, 0x7f0
12345AB7 00000150 1 15 12345000 0 0 00000000  lui   x21, 0x12345
678A8A93 00000154 1 15 12345678 0 0 00000000  addi  x21, x21, 0x678
00001B17 00000158 1 16 00001158 0 0 00000000  auipc x22, 0x1
00510013 0000015C 0 00 00000000 0 0 00000000  addi  x0, x2, 5
00200BB3 00000160 1 17 0000000C 0 0 00000000  add   x23, x0, x2
0020850B 00000164 0 00 00000000 0 0 00000000  custom-0 opcode, bubble
00108463 00000168 0 00 00000000 1 1 00000170  beq   x1, x1, +8
00109463 0000016C 0 00 00000000 1 0 00000174  bne   x1, x1, +8
FE20C8E3 00000170 0 00 00000000 1 1 00000160  blt   x1, x2, -16
0020D463 00000174 0 00 00000000 1 0 0000017C  bge   x1, x2, +8
0020E463 00000178 0 00 00000000 1 0 00000180  bltu  x1, x2, +8
0020F463 0000017C 0 00 00000000 1 1 00000184  bgeu  x1, x2, +8
FE1FFCEF 00000180 1 19 00000184 1 1 00000160  jal   x25, -32
015C8D33 00000184 1 1A 123457FC 0 0 00000000  add   x26, x25, x21

// ==== tb.f ====
+incdir+.
rv_pkg.sv
rv_ifs.sv
instr_fields.sv
control_unit.sv
regfile.sv
execute_stage.sv
datapath_top.sv
wb_checker.sv
tb_datapath.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_datapath
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
